// ==== src/lc3b_mem_params.svh ====
`ifndef LC3B_MEM_PARAMS_SVH
`define LC3B_MEM_PARAMS_SVH

// number of sets in each first-level cache.
// This has to agree with the width of lc3b_index.
`define LC3B_L1_SETS 8

// memory access latency in cycles, at least 1.
`define LC3B_MEM_LATENCY 6

// memory size in lines, enough for the whole 16-bit byte space.
`define LC3B_MEM_WORDS 4096

`endif

// ==== src/lc3b_mem_pkg.sv ====
`default_nettype none

package lc3b_mem_pkg;

	// processor address or data word.
	typedef logic [15:0] lc3b_word;

	// one cache line of eight words, word 0 in the low bits.
	typedef logic [127:0] lc3b_cache_line;

	// byte enables of a word store, bit 0 selects the low byte.
	typedef logic [1:0] lc3b_mem_wmask;

	// byte offset within a line.
	// Bits 3:1 pick the word and bit 0 picks the byte.
	typedef logic [3:0] lc3b_offset;

	// set index, address bits 6:4.
	typedef logic [2:0] lc3b_index;

	// tag, address bits 15:7.
	typedef logic [8:0] lc3b_tag;

endpackage : lc3b_mem_pkg

`default_nettype wire

// ==== src/lc3b_line_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lc3b_mem_params.svh"

module lc3b_line_memory (
	input  logic                         clk,
	input  logic                         rst_n,
	input  lc3b_mem_pkg::lc3b_word       address,
	input  logic                         read,
	input  logic                         write,
	input  lc3b_mem_pkg::lc3b_cache_line wdata,
	output lc3b_mem_pkg::lc3b_cache_line rdata,
	output logic                         mem_resp
);

	localparam int LAT   = `LC3B_MEM_LATENCY;
	localparam int CNT_W = $clog2(LAT + 1);
	localparam int IDX_W = $clog2(`LC3B_MEM_WORDS);

	lc3b_mem_pkg::lc3b_cache_line mem [`LC3B_MEM_WORDS];

	logic             busy;
	logic [CNT_W-1:0] count;
	logic [IDX_W-1:0] line_idx;
	logic             done;

	initial begin
		for (int i = 0; i < `LC3B_MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	assign line_idx = address[4 +: IDX_W];
	assign done     = busy && (count == CNT_W'(LAT));
	assign mem_resp = done;
	assign rdata    = mem[line_idx];

	// count is 1 in the first cycle after the request is taken.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (!busy) begin
			if (read || write) begin
				busy  <= 1'b1;
				count <= CNT_W'(1);
			end
		end else if (done) begin
			busy <= 1'b0;
		end else begin
			count <= count + CNT_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (done && write) begin
			mem[line_idx] <= wdata;
		end
	end

	a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(read && write));

endmodule : lc3b_line_memory

`default_nettype wire

// ==== src/lc3b_mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc3b_mem_arbiter (
	input  logic                         clk,
	input  logic                         rst_n,

	input  lc3b_mem_pkg::lc3b_word       icache_address,
	input  logic                         icache_read,
	input  logic                         icache_write,
	input  lc3b_mem_pkg::lc3b_cache_line icache_wdata,
	output lc3b_mem_pkg::lc3b_cache_line icache_rdata,
	output logic                         icache_mem_resp,

	input  lc3b_mem_pkg::lc3b_word       dcache_address,
	input  logic                         dcache_read,
	input  logic                         dcache_write,
	input  lc3b_mem_pkg::lc3b_cache_line dcache_wdata,
	output lc3b_mem_pkg::lc3b_cache_line dcache_rdata,
	output logic                         dcache_mem_resp,

	input  lc3b_mem_pkg::lc3b_cache_line l2_rdata,
	input  logic                         l2_mem_resp,
	output lc3b_mem_pkg::lc3b_word       l2_address,
	output lc3b_mem_pkg::lc3b_cache_line l2_wdata,
	output logic                         l2_read,
	output logic                         l2_write
);

	typedef enum logic [1:0] {
		grant_idle,
		grant_icache,
		grant_dcache
	} grant_t;

	grant_t state, state_next;

	always_comb begin
		l2_address      = '0;
		l2_wdata        = '0;
		l2_read         = 1'b0;
		l2_write        = 1'b0;
		icache_rdata    = '0;
		icache_mem_resp = 1'b0;
		dcache_rdata    = '0;
		dcache_mem_resp = 1'b0;
		state_next      = state;
		case (state)
			grant_idle: begin
				// instruction fetches take priority.
				if (icache_read) begin
					state_next = grant_icache;
				end else if (dcache_read || dcache_write) begin
					state_next = grant_dcache;
				end
			end
			grant_icache: begin
				l2_address      = icache_address;
				l2_wdata        = icache_wdata;
				l2_read         = icache_read;
				l2_write        = icache_write;
				icache_rdata    = l2_rdata;
				icache_mem_resp = l2_mem_resp;
				if (l2_mem_resp) begin
					state_next = grant_idle;
				end
			end
			grant_dcache: begin
				l2_address      = dcache_address;
				l2_wdata        = dcache_wdata;
				l2_read         = dcache_read;
				l2_write        = dcache_write;
				dcache_rdata    = l2_rdata;
				dcache_mem_resp = l2_mem_resp;
				if (l2_mem_resp) begin
					state_next = grant_idle;
				end
			end
			default: begin
				state_next = grant_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= grant_idle;
		end else begin
			state <= state_next;
		end
	end

	// the granted cache keeps its request up until memory answers.
	a_grant_requested: assert property (@(posedge clk) disable iff (!rst_n)
		(state != grant_idle) |-> (l2_read || l2_write));

endmodule : lc3b_mem_arbiter

`default_nettype wire

// ==== src/lc3b_l1_cache.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lc3b_mem_params.svh"

module lc3b_l1_cache (
	input  logic                        clk,
	input  logic                        rst_n,

	input  lc3b_mem_pkg::lc3b_word      address,
	input  logic                        read,
	input  logic                        write,
	input  lc3b_mem_pkg::lc3b_word      wdata,
	input  lc3b_mem_pkg::lc3b_mem_wmask wmask,
	output lc3b_mem_pkg::lc3b_word      rdata,
	output logic                        resp,

	output lc3b_mem_pkg::lc3b_word       mem_address,
	output logic                        mem_read,
	output logic                        mem_write,
	output lc3b_mem_pkg::lc3b_cache_line mem_wdata,
	input  lc3b_mem_pkg::lc3b_cache_line mem_rdata,
	input  logic                        mem_resp
);

	typedef enum logic [1:0] {
		st_compare,
		st_writeback,
		st_refill,
		st_respond
	} state_t;

	state_t state, state_next;

	lc3b_mem_pkg::lc3b_cache_line data_q [`LC3B_L1_SETS];
	lc3b_mem_pkg::lc3b_tag        tag_q [`LC3B_L1_SETS];
	logic [`LC3B_L1_SETS-1:0]     valid_q;
	logic [`LC3B_L1_SETS-1:0]     dirty_q;
	lc3b_mem_pkg::lc3b_word       rdata_q;

	lc3b_mem_pkg::lc3b_tag        addr_tag;
	lc3b_mem_pkg::lc3b_index      addr_index;
	lc3b_mem_pkg::lc3b_offset     addr_offset;
	logic [6:0]                   bit_base;

	logic                         request;
	logic                         hit;
	logic                         hit_commit;
	logic                         refill_done;
	logic                         commit;
	lc3b_mem_pkg::lc3b_cache_line src_line;
	lc3b_mem_pkg::lc3b_cache_line merged_line;

	assign addr_tag    = address[15:7];
	assign addr_index  = address[6:4];
	assign addr_offset = address[3:0];
	assign bit_base    = {addr_offset[3:1], 4'b0000};

	assign request     = read | write;
	assign hit         = valid_q[addr_index] && (tag_q[addr_index] == addr_tag);
	assign hit_commit  = (state == st_compare) && request && hit;
	assign refill_done = (state == st_refill) && mem_resp;
	assign commit      = hit_commit | refill_done;

	// a refill merges the pending store into the incoming line.
	assign src_line = (state == st_refill) ? mem_rdata : data_q[addr_index];

	always_comb begin
		merged_line = src_line;
		if (write && wmask[0]) begin
			merged_line[bit_base +: 8] = wdata[7:0];
		end
		if (write && wmask[1]) begin
			merged_line[(bit_base + 7'd8) +: 8] = wdata[15:8];
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			st_compare: begin
				if (request) begin
					if (hit) begin
						state_next = st_respond;
					end else if (valid_q[addr_index] && dirty_q[addr_index]) begin
						state_next = st_writeback;
					end else begin
						state_next = st_refill;
					end
				end
			end
			st_writeback: begin
				if (mem_resp) begin
					state_next = st_refill;
				end
			end
			st_refill: begin
				if (mem_resp) begin
					state_next = st_respond;
				end
			end
			st_respond: begin
				state_next = st_compare;
			end
			default: begin
				state_next = st_compare;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= st_compare;
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			state <= state_next;
			if (commit) begin
				valid_q[addr_index] <= 1'b1;
				dirty_q[addr_index] <= write | (hit_commit & dirty_q[addr_index]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (commit) begin
			data_q[addr_index] <= merged_line;
			rdata_q            <= src_line[bit_base +: 16];
		end
		if (refill_done) begin
			tag_q[addr_index] <= addr_tag;
		end
	end

	assign rdata = rdata_q;
	assign resp  = (state == st_respond);

	// write-back uses the stored tag, refill the requested one.
	assign mem_read    = (state == st_refill);
	assign mem_write   = (state == st_writeback);
	assign mem_wdata   = data_q[addr_index];
	assign mem_address = (state == st_writeback) ?
		{tag_q[addr_index], addr_index, 4'b0000} :
		{addr_tag, addr_index, 4'b0000};

	a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(read && write));

	// the processor holds its address across the whole miss sequence.
	a_address_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(request && !resp) |=> $stable(address));

endmodule : lc3b_l1_cache

`default_nettype wire

// ==== src/lc3b_mem_system.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc3b_mem_system (
	input  logic                        clk,
	input  logic                        rst_n,

	input  lc3b_mem_pkg::lc3b_word      i_address,
	input  logic                        i_read,
	output lc3b_mem_pkg::lc3b_word      i_rdata,
	output logic                        i_resp,

	input  lc3b_mem_pkg::lc3b_word      d_address,
	input  logic                        d_read,
	input  logic                        d_write,
	input  lc3b_mem_pkg::lc3b_word      d_wdata,
	input  lc3b_mem_pkg::lc3b_mem_wmask d_wmask,
	output lc3b_mem_pkg::lc3b_word      d_rdata,
	output logic                        d_resp
);

	lc3b_mem_pkg::lc3b_word       ic_mem_address, dc_mem_address, l2_address;
	logic                         ic_mem_read, ic_mem_write, ic_mem_resp;
	logic                         dc_mem_read, dc_mem_write, dc_mem_resp;
	lc3b_mem_pkg::lc3b_cache_line ic_mem_wdata, ic_mem_rdata;
	lc3b_mem_pkg::lc3b_cache_line dc_mem_wdata, dc_mem_rdata;
	lc3b_mem_pkg::lc3b_cache_line l2_wdata, l2_rdata;
	logic                         l2_read, l2_write, l2_mem_resp;

	// the instruction side never stores.
	lc3b_l1_cache u_icache (
		.clk(clk), .rst_n(rst_n),
		.address(i_address), .read(i_read), .write(1'b0),
		.wdata(16'h0000), .wmask(2'b00),
		.rdata(i_rdata), .resp(i_resp),
		.mem_address(ic_mem_address), .mem_read(ic_mem_read), .mem_write(ic_mem_write),
		.mem_wdata(ic_mem_wdata), .mem_rdata(ic_mem_rdata), .mem_resp(ic_mem_resp)
	);

	lc3b_l1_cache u_dcache (
		.clk(clk), .rst_n(rst_n),
		.address(d_address), .read(d_read), .write(d_write),
		.wdata(d_wdata), .wmask(d_wmask),
		.rdata(d_rdata), .resp(d_resp),
		.mem_address(dc_mem_address), .mem_read(dc_mem_read), .mem_write(dc_mem_write),
		.mem_wdata(dc_mem_wdata), .mem_rdata(dc_mem_rdata), .mem_resp(dc_mem_resp)
	);

	lc3b_mem_arbiter u_arbiter (
		.clk(clk), .rst_n(rst_n),
		.icache_address(ic_mem_address), .icache_read(ic_mem_read),
		.icache_write(ic_mem_write), .icache_wdata(ic_mem_wdata),
		.icache_rdata(ic_mem_rdata), .icache_mem_resp(ic_mem_resp),
		.dcache_address(dc_mem_address), .dcache_read(dc_mem_read),
		.dcache_write(dc_mem_write), .dcache_wdata(dc_mem_wdata),
		.dcache_rdata(dc_mem_rdata), .dcache_mem_resp(dc_mem_resp),
		.l2_rdata(l2_rdata), .l2_mem_resp(l2_mem_resp), .l2_address(l2_address),
		.l2_wdata(l2_wdata), .l2_read(l2_read), .l2_write(l2_write)
	);

	lc3b_line_memory u_memory (
		.clk(clk), .rst_n(rst_n),
		.address(l2_address), .read(l2_read), .write(l2_write),
		.wdata(l2_wdata), .rdata(l2_rdata), .mem_resp(l2_mem_resp)
	);

endmodule : lc3b_mem_system

`default_nettype wire

// ==== tb/lc3b_mem_system_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc3b_mem_system_tb;

	localparam int TIMEOUT = 200;

	logic        clk;
	logic        rst_n;
	logic [15:0] i_address;
	logic        i_read;
	logic [15:0] i_rdata;
	logic        i_resp;
	logic [15:0] d_address;
	logic        d_read;
	logic        d_write;
	logic [15:0] d_wdata;
	logic [1:0]  d_wmask;
	logic [15:0] d_rdata;
	logic        d_resp;

	// byte-wide shadow of the data the processor has stored.
	logic [7:0]  shadow [65536];
	int          errors;
	int          checks;
	integer      seed;

	lc3b_mem_system u_dut (
		.clk(clk), .rst_n(rst_n),
		.i_address(i_address), .i_read(i_read), .i_rdata(i_rdata), .i_resp(i_resp),
		.d_address(d_address), .d_read(d_read), .d_write(d_write), .d_wdata(d_wdata),
		.d_wmask(d_wmask), .d_rdata(d_rdata), .d_resp(d_resp)
	);

	always #20 clk = ~clk;

	function automatic logic [15:0] shadow_word(input logic [15:0] addr);
		return {shadow[{addr[15:1], 1'b1}], shadow[{addr[15:1], 1'b0}]};
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 16'h%04h, expected 16'h%04h", name, got, exp);
		end
	endtask

	// waits counts the sampled cycles with resp low, so a hit gives 1.
	task automatic data_access(input logic is_write, input logic [15:0] addr,
		input logic [15:0] wdata, input logic [1:0] wmask,
		output logic [15:0] rdata, output int waits);
		@(posedge clk);
		d_address <= addr;
		d_read    <= !is_write;
		d_write   <= is_write;
		d_wdata   <= wdata;
		d_wmask   <= wmask;
		waits = 0;
		rdata = 'x;
		@(negedge clk);
		while (!d_resp && waits < TIMEOUT) begin
			waits++;
			@(negedge clk);
		end
		if (d_resp) begin
			rdata = d_rdata;
			if (is_write && wmask[0]) begin
				shadow[{addr[15:1], 1'b0}] = wdata[7:0];
			end
			if (is_write && wmask[1]) begin
				shadow[{addr[15:1], 1'b1}] = wdata[15:8];
			end
		end else begin
			errors++;
			$display("timeout: the data port never answered the access to %h", addr);
		end
		@(posedge clk);
		d_read  <= 1'b0;
		d_write <= 1'b0;
	endtask

	task automatic data_write(input logic [15:0] addr, input logic [15:0] wdata,
		input logic [1:0] wmask);
		logic [15:0] discard;
		int          waits;
		data_access(1'b1, addr, wdata, wmask, discard, waits);
	endtask

	task automatic data_load_check(input logic [15:0] addr);
		logic [15:0] got;
		int          waits;
		data_access(1'b0, addr, 16'h0000, 2'b00, got, waits);
		check_value("d_rdata", got, shadow_word(addr));
	endtask

	task automatic fetch_word(input logic [15:0] addr, output logic [15:0] rdata);
		int waits;
		@(posedge clk);
		i_address <= addr;
		i_read    <= 1'b1;
		waits = 0;
		rdata = 'x;
		@(negedge clk);
		while (!i_resp && waits < TIMEOUT) begin
			waits++;
			@(negedge clk);
		end
		if (i_resp) begin
			rdata = i_rdata;
		end else begin
			errors++;
			$display("timeout: the instruction port never answered the fetch from %h", addr);
		end
		@(posedge clk);
		i_read <= 1'b0;
	endtask

	task automatic masked_hits();
		logic [15:0] got;
		logic [15:0] addr;
		int          waits;
		data_write(16'h0104, 16'ha1b2, 2'b11);
		data_write(16'h0106, 16'hffc3, 2'b01);
		data_write(16'h0108, 16'hd4ff, 2'b10);
		for (int i = 0; i < 3; i++) begin
			addr = 16'h0104 + 16'(2 * i);
			data_access(1'b0, addr, 16'h0000, 2'b00, got, waits);
			check_value("d_rdata", got, shadow_word(addr));
			check_value("hit wait cycles", 16'(waits), 16'd1);
		end
	endtask

	task automatic dirty_eviction();
		data_write(16'h0010, 16'h1234, 2'b11);
		data_write(16'h0090, 16'h5678, 2'b11);
		data_load_check(16'h0010);
		data_load_check(16'h0090);
	endtask

	task automatic fetch_after_writeback();
		logic [15:0] got;
		data_write(16'h0200, 16'hbeef, 2'b11);
		// this fetch sees memory before the write-back and leaves a stale line.
		fetch_word(16'h0200, got);
		data_write(16'h0280, 16'h0bad, 2'b11);
		fetch_word(16'h0300, got);
		check_value("i_rdata", got, shadow_word(16'h0300));
		fetch_word(16'h0200, got);
		check_value("i_rdata", got, shadow_word(16'h0200));
	endtask

	task automatic concurrent_misses();
		logic [15:0] i_got;
		logic [15:0] d_got;
		logic        i_done;
		logic        d_done;
		int          waits;
		data_write(16'h0510, 16'hc0de, 2'b11);
		data_write(16'h0522, 16'h5a17, 2'b11);
		data_write(16'h0590, 16'h1111, 2'b11);
		data_write(16'h05a0, 16'h2222, 2'b11);
		@(posedge clk);
		i_address <= 16'h0510;
		i_read    <= 1'b1;
		d_address <= 16'h0522;
		d_read    <= 1'b1;
		i_done = 1'b0;
		d_done = 1'b0;
		waits  = 0;
		while (!(i_done && d_done) && waits < TIMEOUT) begin
			@(negedge clk);
			waits++;
			if (i_resp && !i_done) begin
				i_got  = i_rdata;
				i_done = 1'b1;
			end
			if (d_resp && !d_done) begin
				d_got  = d_rdata;
				d_done = 1'b1;
			end
			@(posedge clk);
			if (i_done) begin
				i_read <= 1'b0;
			end
			if (d_done) begin
				d_read <= 1'b0;
			end
		end
		if (i_done && d_done) begin
			check_value("i_rdata", i_got, shadow_word(16'h0510));
			check_value("d_rdata", d_got, shadow_word(16'h0522));
		end else begin
			errors++;
			$display("timeout: the two concurrent misses did not both complete");
			i_read <= 1'b0;
			d_read <= 1'b0;
		end
	endtask

	// lines 0 to 15 of the window; line bits 2:0 are the set.
	task automatic random_traffic();
		logic [31:0] r;
		logic [15:0] addr;
		logic [15:0] got;
		logic [3:0]  line;
		logic [15:0] dc_held;
		logic [15:0] ic_held;
		logic [15:0] ic_stale;
		int          waits;
		dc_held  = '1;
		ic_held  = '0;
		ic_stale = '0;
		for (int n = 0; n < 200; n++) begin
			r    = $random(seed);
			addr = {8'h00, r[7:1], 1'b0};
			line = addr[7:4];
			if (r[9:8] != 2'b00 && !dc_held[line] && !(ic_held[line] && ic_stale[line])) begin
				fetch_word(addr, got);
				check_value("i_rdata", got, shadow_word(addr));
				ic_held[line]        = 1'b1;
				ic_held[line ^ 4'h8] = 1'b0;
				ic_stale[line]       = 1'b0;
			end else begin
				data_access(r[10], addr, r[31:16], r[12:11], got, waits);
				if (!r[10]) begin
					check_value("d_rdata", got, shadow_word(addr));
				end else if (ic_held[line]) begin
					ic_stale[line] = 1'b1;
				end
				dc_held[line]        = 1'b1;
				dc_held[line ^ 4'h8] = 1'b0;
			end
		end
	endtask

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		i_address = '0;
		i_read    = 1'b0;
		d_address = '0;
		d_read    = 1'b0;
		d_write   = 1'b0;
		d_wdata   = '0;
		d_wmask   = '0;
		errors    = 0;
		checks    = 0;
		seed      = 32'h1f8f_df0b;
		for (int a = 0; a < 65536; a++) begin
			shadow[a] = 8'h00;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("i_resp", {15'b0, i_resp}, 16'h0000);
		check_value("d_resp", {15'b0, d_resp}, 16'h0000);
		masked_hits();
		dirty_eviction();
		fetch_after_writeback();
		concurrent_misses();
		random_traffic();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule : lc3b_mem_system_tb

`default_nettype wire

// ==== lc3b_mem_system.f ====
+incdir+src
src/lc3b_mem_pkg.sv
src/lc3b_line_memory.sv
src/lc3b_mem_arbiter.sv
src/lc3b_l1_cache.sv
src/lc3b_mem_system.sv
tb/lc3b_mem_system_tb.sv

// ==== Bender.yml ====
package:
  name: lc3b_mem_system

sources:
  - include_dirs:
      - src
    files:
      - src/lc3b_mem_pkg.sv
      - src/lc3b_line_memory.sv
      - src/lc3b_mem_arbiter.sv
      - src/lc3b_l1_cache.sv
      - src/lc3b_mem_system.sv
  - target: simulation
    files:
      - tb/lc3b_mem_system_tb.sv
